/* design/scrmbl_pkg.sv */
`default_nettype none

package scrmbl_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths and round bookkeeping
  ////////////////////////////////////////////////////////////////////////////

  localparam int BlockWidth  = 64;
  localparam int KeyWidth    = 128;
  localparam int NumRounds   = 31;
  // the round index runs from 1 up to NumRounds and fits in five bits
  localparam int IdxWidth    = 5;
  localparam int NumKeys     = 4;
  localparam int KeySelWidth = 2;
  localparam int StateWidth  = 9;

  localparam logic [IdxWidth-1:0] FirstRoundIdx = IdxWidth'(1);
  localparam logic [IdxWidth-1:0] LastRoundIdx  = IdxWidth'(NumRounds);
  // the controller counts from zero, so the last round sits one below NumRounds
  localparam logic [IdxWidth-1:0] LastRoundCnt  = IdxWidth'(NumRounds - 1);

  // entry 0 stays all zero so that the published PRESENT-128 vector applies
  localparam logic [NumKeys-1:0][KeyWidth-1:0] ScrmblKeys = {
    128'h8e47_b2d0_5c91_f36a_2db8_0475_e9c3_a16f,
    128'hd51f_7e20_a9c4_36b8_0f6d_e287_4b19_c53a,
    128'h3ba0_8c5e_14f7_92d6_6a0e_c1b3_58f4_27d9,
    128'h0
  };

  // PRESENT 4-bit S-box and its inverse, nibble 0 holds the image of 0
  localparam logic [15:0][3:0] PresentSbox    = 64'h2174_8FE3_DA09_B65C;
  localparam logic [15:0][3:0] PresentSboxInv = 64'hA970_364B_D21C_8FE5;

  ////////////////////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////////////////////

  // the two upper codes are reserved and get ignored by the engine
  typedef enum logic [1:0] {
    CmdEncrypt   = 2'b00,
    CmdDecrypt   = 2'b01,
    CmdReserved2 = 2'b10,
    CmdReserved3 = 2'b11
  } scrmbl_cmd_e;

  // sparse encoding with a minimum Hamming distance of five between states
  typedef enum logic [StateWidth-1:0] {
    IdleSt    = 9'b100011001,
    DecryptSt = 9'b101101111,
    EncryptSt = 9'b010010111,
    ErrorSt   = 9'b011111000
  } scrmbl_state_e;

  // what the working registers take on a load
  typedef enum logic [1:0] {
    LoadEncInit,
    LoadDecInit,
    LoadEncRound,
    LoadDecRound
  } load_sel_e;

  typedef struct packed {
    scrmbl_cmd_e            cmd;
    logic [KeySelWidth-1:0] sel;
    logic [BlockWidth-1:0]  data;
  } scrmbl_req_t;

  // everything a single iterative round reads and writes back
  typedef struct packed {
    logic [BlockWidth-1:0] data;
    logic [KeyWidth-1:0]   key;
    logic [IdxWidth-1:0]   idx;
  } round_state_t;

  ////////////////////////////////////////////////////////////////////////////
  // key schedule
  ////////////////////////////////////////////////////////////////////////////

  // one forward step of the 128-bit schedule: rotate left by 61, push the
  // two top nibbles through the S-box and fold the round counter in
  function automatic logic [KeyWidth-1:0] present_update_key(logic [KeyWidth-1:0] key,
                                                             logic [IdxWidth-1:0] idx);
    logic [KeyWidth-1:0] k;
    k          = {key[66:0], key[127:67]};
    k[127:124] = PresentSbox[k[127:124]];
    k[123:120] = PresentSbox[k[123:120]];
    k[66:62]   = k[66:62] ^ idx;
    return k;
  endfunction

  // decryption starts from the key that follows the last round, which is
  // found by running the forward schedule over all rounds
  function automatic logic [KeyWidth-1:0] present_dec_key(logic [KeyWidth-1:0] key);
    logic [KeyWidth-1:0] k;
    k = key;
    for (int i = 1; i <= NumRounds; i++) begin
      k = present_update_key(k, IdxWidth'(i));
    end
    return k;
  endfunction

endpackage

`default_nettype wire

/* design/present_round.sv */
`timescale 1ns/1ns
`default_nettype none

module present_round (
  input  scrmbl_pkg::round_state_t cur_i,
  output scrmbl_pkg::round_state_t enc_next_o,
  output scrmbl_pkg::round_state_t dec_next_o
);

  import scrmbl_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // layer functions
  ////////////////////////////////////////////////////////////////////////////

  // sixteen S-boxes side by side over the whole block
  function automatic logic [BlockWidth-1:0] sbox_layer(logic [BlockWidth-1:0] d,
                                                       logic inv);
    logic [BlockWidth-1:0] r;
    for (int i = 0; i < BlockWidth / 4; i++) begin
      if (inv) begin
        r[4*i +: 4] = PresentSboxInv[d[4*i +: 4]];
      end else begin
        r[4*i +: 4] = PresentSbox[d[4*i +: 4]];
      end
    end
    return r;
  endfunction

  // bit i moves to 16*i mod 63, bit 63 stays where it is
  // the inverse simply reads from the position the forward layer writes to
  function automatic logic [BlockWidth-1:0] perm_layer(logic [BlockWidth-1:0] d,
                                                       logic inv);
    logic [BlockWidth-1:0] r;
    int unsigned           pos;
    for (int i = 0; i < BlockWidth; i++) begin
      pos = (i == BlockWidth - 1) ? i : (i * 16) % (BlockWidth - 1);
      if (inv) begin
        r[i] = d[pos];
      end else begin
        r[pos] = d[i];
      end
    end
    return r;
  endfunction

  // undoes present_update_key step by step in reverse order
  function automatic logic [KeyWidth-1:0] key_step_back(logic [KeyWidth-1:0] key,
                                                        logic [IdxWidth-1:0] idx);
    logic [KeyWidth-1:0] k;
    k          = key;
    k[66:62]   = k[66:62] ^ idx;
    k[127:124] = PresentSboxInv[k[127:124]];
    k[123:120] = PresentSboxInv[k[123:120]];
    // rotate right by 61
    return {k[60:0], k[127:61]};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // encrypt round
  ////////////////////////////////////////////////////////////////////////////

  logic                  last_idx;
  logic [BlockWidth-1:0] enc_data, dec_data;
  logic [KeyWidth-1:0]   enc_key, dec_key;

  // the outermost round also carries the whitening key addition
  assign last_idx = (cur_i.idx == LastRoundIdx);

  always_comb begin : p_enc
    // round key is always the top half of the key register
    enc_data = cur_i.data ^ cur_i.key[KeyWidth-1 -: BlockWidth];
    enc_data = sbox_layer(enc_data, 1'b0);
    enc_data = perm_layer(enc_data, 1'b0);
    enc_key  = present_update_key(cur_i.key, cur_i.idx);
    if (last_idx) begin
      enc_data = enc_data ^ enc_key[KeyWidth-1 -: BlockWidth];
    end
    enc_next_o.data = enc_data;
    enc_next_o.key  = enc_key;
    enc_next_o.idx  = cur_i.idx + IdxWidth'(1);
  end

  ////////////////////////////////////////////////////////////////////////////
  // decrypt round
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin : p_dec
    dec_data = cur_i.data;
    // the first decrypt round strips the whitening key
    if (last_idx) begin
      dec_data = dec_data ^ cur_i.key[KeyWidth-1 -: BlockWidth];
    end
    // step the key back first, this round needs the key of the round below
    dec_key  = key_step_back(cur_i.key, cur_i.idx);
    dec_data = perm_layer(dec_data, 1'b1);
    dec_data = sbox_layer(dec_data, 1'b1);
    dec_data = dec_data ^ dec_key[KeyWidth-1 -: BlockWidth];
    dec_next_o.data = dec_data;
    dec_next_o.key  = dec_key;
    dec_next_o.idx  = cur_i.idx - IdxWidth'(1);
  end

endmodule

`default_nettype wire

/* design/scrmbl_key_table.sv */
`timescale 1ns/1ns
`default_nettype none

module scrmbl_key_table (
  input  logic [scrmbl_pkg::KeySelWidth-1:0] sel_i,
  input  logic                               decrypt_i,
  output logic [scrmbl_pkg::KeyWidth-1:0]    key_o
);

  import scrmbl_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // key lookup tables
  ////////////////////////////////////////////////////////////////////////////

  // NumKeys is a power of two, so every value of sel_i hits a filled entry
  logic [NumKeys-1:0][KeyWidth-1:0] enc_lut;
  logic [NumKeys-1:0][KeyWidth-1:0] dec_lut;

  for (genvar k = 0; k < NumKeys; k++) begin : gen_lut
    assign enc_lut[k] = ScrmblKeys[k];
    // the argument is a constant, so the 31 schedule steps fold into a
    // fixed table and decryption can start without a key warm-up
    assign dec_lut[k] = present_dec_key(ScrmblKeys[k]);
  end

  ////////////////////////////////////////////////////////////////////////////
  // selection
  ////////////////////////////////////////////////////////////////////////////

  // index first, then direction
  always_comb begin : p_sel
    if (decrypt_i) begin
      key_o = dec_lut[sel_i];
    end else begin
      key_o = enc_lut[sel_i];
    end
  end

endmodule

`default_nettype wire

/* design/scrmbl_state_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module scrmbl_state_regs (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              load_en_i,
  input  scrmbl_pkg::load_sel_e             load_sel_i,
  input  logic [scrmbl_pkg::BlockWidth-1:0] data_i,
  input  logic [scrmbl_pkg::KeyWidth-1:0]   init_key_i,
  input  scrmbl_pkg::round_state_t          enc_next_i,
  input  scrmbl_pkg::round_state_t          dec_next_i,
  output scrmbl_pkg::round_state_t          cur_o
);

  import scrmbl_pkg::*;

  round_state_t cur_d, cur_q;

  ////////////////////////////////////////////////////////////////////////////
  // input mux
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin : p_mux
    cur_d = cur_q;
    unique case (load_sel_i)
      // encryption walks the index upwards from the first round
      LoadEncInit: begin
        cur_d.data = data_i;
        cur_d.key  = init_key_i;
        cur_d.idx  = FirstRoundIdx;
      end
      // decryption walks it down from the last round
      LoadDecInit: begin
        cur_d.data = data_i;
        cur_d.key  = init_key_i;
        cur_d.idx  = LastRoundIdx;
      end
      LoadEncRound: begin
        cur_d = enc_next_i;
      end
      LoadDecRound: begin
        cur_d = dec_next_i;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // working registers
  ////////////////////////////////////////////////////////////////////////////

  // data, key and index always move together
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      cur_q <= '0;
    end else if (load_en_i) begin
      cur_q <= cur_d;
    end
  end

  assign cur_o = cur_q;

endmodule

`default_nettype wire

/* design/scrmbl_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module scrmbl_ctrl (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  scrmbl_pkg::scrmbl_cmd_e         cmd_i,
  input  logic                            valid_i,
  input  logic                            escalate_en_i,
  input  logic [scrmbl_pkg::IdxWidth-1:0] idx_i,
  output logic                            ready_o,
  output logic                            load_en_o,
  output scrmbl_pkg::load_sel_e           load_sel_o,
  output logic                            valid_o,
  output logic                            fsm_err_o
);

  import scrmbl_pkg::*;

  scrmbl_state_e       state_d, state_q;
  logic [IdxWidth-1:0] cnt_q;
  logic                cnt_clr, cnt_en;
  logic                valid_d, valid_q;
  logic                last_round;

  // the counter bounds the run on its own, and the index in the working
  // registers ends it as well, so a disturbed index cannot stretch an operation
  assign last_round = (cnt_q == LastRoundCnt) ||
                      ((state_q == EncryptSt) && (idx_i == LastRoundIdx)) ||
                      ((state_q == DecryptSt) && (idx_i == FirstRoundIdx));

  ////////////////////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin : p_fsm
    state_d    = state_q;
    load_en_o  = 1'b0;
    load_sel_o = LoadEncInit;
    cnt_clr    = 1'b0;
    cnt_en     = 1'b0;
    valid_d    = 1'b0;
    ready_o    = 1'b0;
    fsm_err_o  = 1'b0;

    unique case (state_q)
      // wait for a command and load the initial round state
      IdleSt: begin
        ready_o = 1'b1;
        cnt_clr = 1'b1;
        if (valid_i) begin
          unique case (cmd_i)
            CmdEncrypt: begin
              state_d    = EncryptSt;
              load_en_o  = 1'b1;
              load_sel_o = LoadEncInit;
            end
            CmdDecrypt: begin
              state_d    = DecryptSt;
              load_en_o  = 1'b1;
              load_sel_o = LoadDecInit;
            end
            // reserved codes are taken and dropped
            default: begin
              state_d = IdleSt;
            end
          endcase
        end
      end
      EncryptSt: begin
        load_en_o  = 1'b1;
        load_sel_o = LoadEncRound;
        cnt_en     = 1'b1;
        if (last_round) begin
          state_d = IdleSt;
          valid_d = 1'b1;
        end
      end
      DecryptSt: begin
        load_en_o  = 1'b1;
        load_sel_o = LoadDecRound;
        cnt_en     = 1'b1;
        if (last_round) begin
          state_d = IdleSt;
          valid_d = 1'b1;
        end
      end
      // terminal, only a reset leaves it
      ErrorSt: begin
        fsm_err_o = 1'b1;
      end
      // any other encoding means the state register was hit
      default: begin
        state_d   = ErrorSt;
        fsm_err_o = 1'b1;
      end
    endcase

    // escalation wins over everything and kills a pending result
    if (escalate_en_i) begin
      state_d   = ErrorSt;
      load_en_o = 1'b0;
      valid_d   = 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      state_q <= IdleSt;
      cnt_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      state_q <= state_d;
      valid_q <= valid_d;
      if (cnt_clr) begin
        cnt_q <= '0;
      end else if (cnt_en) begin
        cnt_q <= cnt_q + IdxWidth'(1);
      end
    end
  end

  assign valid_o = valid_q;

endmodule

`default_nettype wire

/* design/otp_scrmbl_top.sv */
`timescale 1ns/1ns
`default_nettype none

module otp_scrmbl_top (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  scrmbl_pkg::scrmbl_req_t           req_i,
  input  logic                              valid_i,
  input  logic                              escalate_en_i,
  output logic                              ready_o,
  output logic [scrmbl_pkg::BlockWidth-1:0] data_o,
  output logic                              valid_o,
  output logic                              fsm_err_o
);

  import scrmbl_pkg::*;

  logic                load_en;
  load_sel_e           load_sel;
  logic                key_decrypt;
  logic [KeyWidth-1:0] init_key;
  round_state_t        cur;
  round_state_t        enc_next;
  round_state_t        dec_next;

  ////////////////////////////////////////////////////////////////////////////
  // control and key selection
  ////////////////////////////////////////////////////////////////////////////

  scrmbl_ctrl u_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .cmd_i         (req_i.cmd),
    .valid_i       (valid_i),
    .escalate_en_i (escalate_en_i),
    .idx_i         (cur.idx),
    .ready_o       (ready_o),
    .load_en_o     (load_en),
    .load_sel_o    (load_sel),
    .valid_o       (valid_o),
    .fsm_err_o     (fsm_err_o)
  );

  // the key only matters on an init load, where the load select tells the direction
  assign key_decrypt = (load_sel == LoadDecInit);

  scrmbl_key_table u_key_table (
    .sel_i     (req_i.sel),
    .decrypt_i (key_decrypt),
    .key_o     (init_key)
  );

  ////////////////////////////////////////////////////////////////////////////
  // working registers and round datapath
  ////////////////////////////////////////////////////////////////////////////

  scrmbl_state_regs u_state_regs (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .load_en_i  (load_en),
    .load_sel_i (load_sel),
    .data_i     (req_i.data),
    .init_key_i (init_key),
    .enc_next_i (enc_next),
    .dec_next_i (dec_next),
    .cur_o      (cur)
  );

  present_round u_present_round (
    .cur_i      (cur),
    .enc_next_o (enc_next),
    .dec_next_o (dec_next)
  );

  // intermediate round states never leave the block
  assign data_o = valid_o ? cur.data : '0;

endmodule

`default_nettype wire

/* sim/tb_otp_scrmbl.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_otp_scrmbl;

  import scrmbl_pkg::*;

  logic                  clk_i = 1'b0;
  logic                  rst_ni;
  scrmbl_req_t           req_i;
  logic                  valid_i;
  logic                  escalate_en_i;
  logic                  ready_o;
  logic [BlockWidth-1:0] data_o;
  logic                  valid_o;
  logic                  fsm_err_o;

  integer                seed = 32'ha304;
  int                    proto_errs = 0;
  int                    value_errs = 0;
  // rising edges seen since the last accepted encrypt or decrypt, parked at all ones
  logic [7:0]            edges_since_acc;

  otp_scrmbl_top otp_scrmbl_top_inst (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .valid_i       (valid_i),
    .escalate_en_i (escalate_en_i),
    .ready_o       (ready_o),
    .data_o        (data_o),
    .valid_o       (valid_o),
    .fsm_err_o     (fsm_err_o)
  );

  initial begin
    forever #2 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // protocol checks
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      edges_since_acc <= 8'hff;
    end else if (ready_o && valid_i &&
                 (req_i.cmd == CmdEncrypt || req_i.cmd == CmdDecrypt)) begin
      edges_since_acc <= 8'd0;
    end else if (edges_since_acc != 8'hff) begin
      edges_since_acc <= edges_since_acc + 8'd1;
    end
  end

  // intermediate round data must never show on the output
  a_data_gated: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !valid_o |-> (data_o == '0))
    else begin
      proto_errs = proto_errs + 1;
      $display("ERR @%0t: data_o is not zero while valid_o is low", $time);
    end

  a_valid_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o |=> !valid_o)
    else begin
      proto_errs = proto_errs + 1;
      $display("ERR @%0t: valid_o is high for more than one cycle", $time);
    end

  // one round per clock, so the result shows exactly 31 edges after the accept
  a_valid_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o |-> (edges_since_acc == 8'd31))
    else begin
      proto_errs = proto_errs + 1;
      $display("ERR @%0t: valid_o after %0d edges, expected 31", $time, edges_since_acc);
    end

  // the engine is idle again in the cycle that carries the result
  a_ready_with_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o |-> ready_o)
    else begin
      proto_errs = proto_errs + 1;
      $display("ERR @%0t: ready_o is low in the valid_o cycle", $time);
    end

  a_busy_not_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (edges_since_acc < 8'd31) |-> !ready_o)
    else begin
      proto_errs = proto_errs + 1;
      $display("ERR @%0t: ready_o is high while an operation runs", $time);
    end

  a_escalate: assert property (@(posedge clk_i) disable iff (!rst_ni)
    escalate_en_i |=> fsm_err_o)
    else begin
      proto_errs = proto_errs + 1;
      $display("ERR @%0t: fsm_err_o did not follow escalate_en_i", $time);
    end

  // the error state is terminal and silent
  a_error_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni)
    fsm_err_o |-> (!ready_o && !valid_o))
    else begin
      proto_errs = proto_errs + 1;
      $display("ERR @%0t: ready_o or valid_o high in the error state", $time);
    end

  ////////////////////////////////////////////////////////////////////////////
  // helper tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic log_mismatch(input string msg);
    value_errs = value_errs + 1;
    $display("ERR @%0t: %s", $time, msg);
  endtask

  task automatic abort_on_timeout(input string what);
    $display("timeout: %s did not happen in time, run stopped", what);
    $display("Simulation failed");
    $finish;
  endtask

  // every task ends on a falling edge, so the next one starts on one
  task automatic apply_reset();
    rst_ni        = 1'b0;
    valid_i       = 1'b0;
    escalate_en_i = 1'b0;
    req_i         = '0;
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    assert (ready_o && !valid_o && !fsm_err_o)
      else log_mismatch("outputs after reset are not ready=1 valid=0 err=0");
  endtask

  task automatic wait_ready();
    int unsigned n;
    n = 0;
    while (!ready_o) begin
      @(negedge clk_i);
      n++;
      if (n > 100) abort_on_timeout("ready_o");
    end
  endtask

  // one full operation, the result is taken in the valid_o cycle
  task automatic run_op(input scrmbl_cmd_e cmd, input logic [1:0] sel,
                        input logic [63:0] din, output logic [63:0] dout);
    int unsigned n;
    wait_ready();
    req_i.cmd  = cmd;
    req_i.sel  = sel;
    req_i.data = din;
    valid_i    = 1'b1;
    @(negedge clk_i);
    valid_i = 1'b0;
    n = 0;
    while (!valid_o) begin
      @(negedge clk_i);
      n++;
      if (n > 100) abort_on_timeout("valid_o");
    end
    dout = data_o;
    @(negedge clk_i);
  endtask

  task automatic check_reserved(input scrmbl_cmd_e cmd);
    wait_ready();
    req_i.cmd  = cmd;
    req_i.sel  = 2'd1;
    req_i.data = 64'h0123_4567_89ab_cdef;
    valid_i    = 1'b1;
    @(negedge clk_i);
    valid_i = 1'b0;
    // nothing starts, so the port stays idle for the whole window
    repeat (40) begin
      assert (ready_o) else log_mismatch("ready_o dropped after a reserved opcode");
      assert (!valid_o) else log_mismatch("valid_o rose after a reserved opcode");
      @(negedge clk_i);
    end
  endtask

  task automatic escalate_mid_op();
    logic [31:0] rnd;
    wait_ready();
    req_i.cmd  = CmdEncrypt;
    req_i.sel  = 2'd2;
    req_i.data = 64'hfeed_face_cafe_beef;
    valid_i    = 1'b1;
    @(negedge clk_i);
    valid_i = 1'b0;
    repeat (10) @(negedge clk_i);
    escalate_en_i = 1'b1;
    @(negedge clk_i);
    escalate_en_i = 1'b0;
    assert (fsm_err_o) else log_mismatch("fsm_err_o low after escalation");
    // keep knocking, the engine must not answer until reset
    repeat (60) begin
      rnd        = $random(seed);
      req_i.cmd  = CmdEncrypt;
      req_i.sel  = rnd[1:0];
      req_i.data = {rnd, ~rnd};
      valid_i    = 1'b1;
      @(negedge clk_i);
      assert (fsm_err_o && !ready_o && !valid_o)
        else log_mismatch("engine left the error state before reset");
    end
    valid_i = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [63:0] blk, ct, ct_alt, pt;
    logic [31:0] rnd;
    logic [1:0]  sel;
    apply_reset();

    // published PRESENT-128 vector with the all-zero key in entry 0
    run_op(CmdEncrypt, 2'd0, 64'h0, ct);
    assert (ct == 64'h96db702a2e6900af)
      else log_mismatch($sformatf("known answer got %h", ct));
    run_op(CmdDecrypt, 2'd0, 64'h96db702a2e6900af, pt);
    assert (pt == 64'h0) else log_mismatch($sformatf("known answer decrypt got %h", pt));

    for (int i = 0; i < 20; i++) begin
      blk[63:32] = $random(seed);
      blk[31:0]  = $random(seed);
      rnd        = $random(seed);
      sel        = rnd[1:0];
      run_op(CmdEncrypt, sel, blk, ct);
      run_op(CmdDecrypt, sel, ct, pt);
      assert (pt == blk)
        else log_mismatch($sformatf("round trip key %0d: %h came back as %h", sel, blk, pt));
      run_op(CmdEncrypt, sel + 2'd1, blk, ct_alt);
      assert (ct_alt != ct)
        else log_mismatch($sformatf("keys %0d and %0d give the same ciphertext", sel,
                                    sel + 2'd1));
    end

    check_reserved(CmdReserved2);
    check_reserved(CmdReserved3);

    escalate_mid_op();
    apply_reset();
    // the engine works again once reset clears the error state
    run_op(CmdEncrypt, 2'd0, 64'h0, ct);
    assert (ct == 64'h96db702a2e6900af)
      else log_mismatch($sformatf("known answer after reset got %h", ct));

    repeat (4) @(negedge clk_i);
    $display("errors: assertion=%0d check=%0d", proto_errs, value_errs);
    if (proto_errs == 0 && value_errs == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
design/scrmbl_pkg.sv
design/present_round.sv
design/scrmbl_key_table.sv
design/scrmbl_state_regs.sv
design/scrmbl_ctrl.sv
design/otp_scrmbl_top.sv
sim/tb_otp_scrmbl.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module tb_otp_scrmbl -f compile.f -Mdir obj_dir -o sim_tb \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -q "Simulation failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
